/* compile.f */
+incdir+testbench
hw/prf_pkg.sv
hw/phys_reg_file.sv
hw/cdb_arbiter.sv
hw/operand_fetch.sv
hw/prf_subsystem_top.sv
testbench/tb_prf_subsystem.sv

/* testbench/prf_ref_model.svh */
`ifndef PRF_REF_MODEL_SVH
`define PRF_REF_MODEL_SVH

// reference model of arbiter slots, register array and forwarding
// steps on the inputs en, fu_result and issue_req of the testbench module

arb_state_t      m_state [NUM_FU];    // slot state per unit
fu_result_t      m_slot  [NUM_FU];    // parked result per unit
reg_data_t       m_regs  [NUM_PREG];  // register array
cdb_packet_t     m_cdb;               // expected bus after the last edge
operand_packet_t m_ops   [NUM_FU];    // expected operand packets

task automatic model_reset();
  m_cdb = '0;
  for (int k = 0; k < NUM_FU; k++) begin
    m_state[k] = slot_empty;
    m_slot[k]  = '0;
    m_ops[k]   = '0;
  end
  for (int i = 0; i < NUM_PREG; i++) begin
    m_regs[i] = '0;
  end
endtask

// zero reg wins, then the bus, then the array
function automatic reg_data_t model_read(preg_idx_t tag);
  if (tag == ZERO_PREG) return '0;
  if (m_cdb.valid && (tag == m_cdb.tag)) return m_cdb.value;
  return m_regs[tag];
endfunction

// slot holds something at the coming edge
function automatic logic model_pending(int k, logic en_now, logic res_valid);
  return (m_state[k] == slot_full) || (en_now && res_valid);
endfunction

// full slot behind a lower pending one, or frozen
function automatic logic model_stall(int k, logic en_now, logic [NUM_FU-1:0] res_valid);
  logic lower;
  lower = 1'b0;
  for (int j = 0; j < k; j++) begin
    lower = lower | model_pending(j, en_now, res_valid[j]);
  end
  return !en_now || ((m_state[k] == slot_full) && lower);
endfunction

task automatic model_step();
  logic granted;
  granted = 1'b0;
  if (en) begin
    for (int k = 0; k < NUM_FU; k++) begin
      m_ops[k].valid = issue_req[k].valid;
      if (issue_req[k].valid) begin
        m_ops[k].opa = model_read(issue_req[k].src1);  // reads see the old bus
        m_ops[k].opb = model_read(issue_req[k].src2);
      end
    end
    if (m_cdb.valid && (m_cdb.tag != ZERO_PREG)) m_regs[m_cdb.tag] = m_cdb.value;
    m_cdb.valid = 1'b0;
    for (int k = 0; k < NUM_FU; k++) begin
      if ((m_state[k] == slot_full) && !granted) begin
        granted    = 1'b1;                               // lowest index first
        m_cdb      = '{1'b1, m_slot[k].tag, m_slot[k].value};
        m_state[k] = slot_empty;                         // free for a new result
      end
      if ((m_state[k] == slot_empty) && fu_result[k].valid) begin
        m_state[k] = slot_full;                          // captured this edge
        m_slot[k]  = fu_result[k];
      end
      if ((m_state[k] == slot_full) && !granted) begin
        granted    = 1'b1;                               // fresh result goes straight out
        m_cdb      = '{1'b1, m_slot[k].tag, m_slot[k].value};
        m_state[k] = slot_empty;
      end
    end
  end
endtask

`endif

/* testbench/tb_prf_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

// register file subsystem testbench, directed start then seeded random traffic
module tb_prf_subsystem import prf_pkg::*; ();

  localparam int NUM_FU         = 2;
  localparam int RESET_CYCLES   = 16;
  localparam int RANDOM_CYCLES  = 3000;
  localparam int TIMEOUT_CYCLES = (RESET_CYCLES + RANDOM_CYCLES) * 4 / 3;  // directed part is small

  logic              clock;
  logic              reset;
  logic              en;
  fu_result_t        fu_result [NUM_FU];
  logic [NUM_FU-1:0] fu_stall;
  read_req_t         issue_req [NUM_FU];
  cdb_packet_t       cdb;
  operand_packet_t   operands  [NUM_FU];

  logic [31:0] rng_state;        // lcg state
  int          err_count;
  int          check_count;
  int          cycle_count = 0;  // free running, feeds the timeout

  `include "prf_ref_model.svh"

  prf_subsystem_top #(
    .NUM_FU    (NUM_FU)
  ) i_dut (
    .clock     (clock),
    .reset     (reset),
    .en        (en),
    .fu_result (fu_result),
    .fu_stall  (fu_stall),
    .issue_req (issue_req),
    .cdb       (cdb),
    .operands  (operands)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;  // 10 ns period
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // half the tags crowd into 56..63 so hits and tag 63 come often
  function automatic preg_idx_t pick_tag();
    logic [31:0] r;
    r = next_rand();
    if (r[31]) return preg_idx_t'(6'h38 | r[26:24]);
    return r[29:24];
  endfunction

  // valid bits of the results now on the inputs
  function automatic logic [NUM_FU-1:0] result_valids();
    logic [NUM_FU-1:0] v;
    for (int k = 0; k < NUM_FU; k++) begin
      v[k] = fu_result[k].valid;
    end
    return v;
  endfunction

  task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %s got %h expected %h at cycle %0d", name, got, exp, cycle_count);
    end
  endtask

  task automatic check_outputs();
    check_val("cdb.valid", cdb.valid, m_cdb.valid);
    if (m_cdb.valid) begin
      check_val("cdb.tag", cdb.tag, m_cdb.tag);
      check_val("cdb.value", cdb.value, m_cdb.value);
    end
    for (int k = 0; k < NUM_FU; k++) begin
      check_val($sformatf("fu_stall[%0d]", k), fu_stall[k], model_stall(k, en, result_valids()));
      check_val($sformatf("operands[%0d].valid", k), operands[k].valid, m_ops[k].valid);
      if (m_ops[k].valid) begin                      // values held otherwise
        check_val($sformatf("operands[%0d].opa", k), operands[k].opa, m_ops[k].opa);
        check_val($sformatf("operands[%0d].opb", k), operands[k].opb, m_ops[k].opb);
      end
    end
  endtask

  task automatic begin_cycle();
    @(posedge clock);
    model_step();  // inputs of the ending cycle, before the new drive
  endtask

  task automatic end_cycle();
    @(negedge clock);
    check_outputs();  // mid cycle, everything settled
  endtask

  task automatic drive_result(int k, logic v, preg_idx_t dst, reg_data_t val);
    fu_result[k] <= '{valid: v, tag: dst, value: val};
  endtask

  task automatic drive_issue(int k, logic v, preg_idx_t s1, preg_idx_t s2);
    issue_req[k] <= '{valid: v, src1: s1, src2: s2};
  endtask

  task automatic drive_random();
    logic [31:0]       r;
    logic              en_next;
    logic [NUM_FU-1:0] res_next;  // results offered this cycle
    r = next_rand();
    en_next = (r[31:28] != 4'h0);  // frozen about one cycle in sixteen
    res_next = '0;
    en <= en_next;
    for (int k = 0; k < NUM_FU; k++) begin
      r = next_rand();
      if (r[31] && !model_stall(k, en_next, res_next)) begin  // lower units already chosen
        res_next[k] = 1'b1;
        drive_result(k, 1'b1, pick_tag(), {next_rand(), next_rand()});
      end else begin
        drive_result(k, 1'b0, '0, '0);
      end
      drive_issue(k, r[30], r[29] ? m_cdb.tag : pick_tag(), r[28] ? m_cdb.tag : pick_tag());
    end
  endtask

  initial begin
    rng_state   = 32'd30;
    err_count   = 0;
    check_count = 0;
    reset       = 1'b1;
    en          = 1'b1;
    for (int k = 0; k < NUM_FU; k++) begin
      fu_result[k] = '0;
      issue_req[k] = '0;
    end
    model_reset();
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    end_cycle();                                     // reset state
    for (int t = 0; t < NUM_PREG; t += 2 * NUM_FU) begin
      begin_cycle();
      for (int k = 0; k < NUM_FU; k++) begin
        drive_issue(k, 1'b1, preg_idx_t'(t + 2 * k), preg_idx_t'(t + 2 * k + 1));
      end
      end_cycle();                                   // all registers read zero
    end
    begin_cycle();
    drive_result(0, 1'b1, 6'd5, 64'h0123_4567_89ab_cdef);
    drive_result(1, 1'b1, ZERO_PREG, 64'hdead_beef_cafe_f00d);  // dropped write
    drive_issue(0, 1'b0, '0, '0);
    drive_issue(1, 1'b0, '0, '0);
    end_cycle();
    begin_cycle();
    drive_result(0, 1'b1, 6'd7, 64'h1111_2222_3333_4444);     // keeps unit 1 stalled
    drive_result(1, 1'b0, '0, '0);
    drive_issue(0, 1'b1, 6'd5, ZERO_PREG);                    // forward from the bus
    end_cycle();
    for (int i = 0; i < 3; i++) begin
      begin_cycle();
      drive_result(0, 1'b0, '0, '0);
      drive_issue(0, 1'b1, 6'd5, 6'd7);                       // reads after write back
      drive_issue(1, 1'b1, ZERO_PREG, 6'd7);
      end_cycle();
    end
    for (int i = 0; i < 4; i++) begin
      begin_cycle();
      en <= 1'b0;                                             // frozen, nothing moves
      drive_issue(0, 1'b1, 6'd1, 6'd2);
      end_cycle();
    end
    repeat (RANDOM_CYCLES) begin
      begin_cycle();
      drive_random();
      end_cycle();
    end
    $display("checks %0d errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/prf_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

// register file subsystem: cdb arbiter, register file, operand fetch
module prf_subsystem_top import prf_pkg::*; #(
  parameter int NUM_FU = 2                        // functional unit count
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              en,                   // global freeze when low
  input  fu_result_t        fu_result [NUM_FU],   // results from the units
  output logic [NUM_FU-1:0] fu_stall,             // per-unit hold-off level
  input  read_req_t         issue_req [NUM_FU],   // issue requests
  output cdb_packet_t       cdb,                  // bus broadcast, also visible
  output operand_packet_t   operands  [NUM_FU]    // operands towards the units
);

  preg_idx_t rd_tag_a [NUM_FU];   // fetch to prf, src1 tags
  preg_idx_t rd_tag_b [NUM_FU];   // fetch to prf, src2 tags
  reg_data_t rd_val_a [NUM_FU];   // prf to fetch, src1 values
  reg_data_t rd_val_b [NUM_FU];   // prf to fetch, src2 values

  cdb_arbiter #(
    .NUM_FU    (NUM_FU)
  ) i_cdb_arbiter (
    .clock     (clock),
    .reset     (reset),
    .en        (en),
    .fu_result (fu_result),
    .fu_stall  (fu_stall),
    .cdb       (cdb)
  );

  // write port and bypass source are both the cdb
  phys_reg_file #(
    .NUM_FU    (NUM_FU)
  ) i_phys_reg_file (
    .clock     (clock),
    .reset     (reset),
    .en        (en),
    .cdb       (cdb),
    .rd_tag_a  (rd_tag_a),
    .rd_tag_b  (rd_tag_b),
    .rd_val_a  (rd_val_a),
    .rd_val_b  (rd_val_b)
  );

  operand_fetch #(
    .NUM_FU    (NUM_FU)
  ) i_operand_fetch (
    .clock     (clock),
    .reset     (reset),
    .en        (en),
    .issue_req (issue_req),
    .rd_tag_a  (rd_tag_a),
    .rd_tag_b  (rd_tag_b),
    .rd_val_a  (rd_val_a),
    .rd_val_b  (rd_val_b),
    .operands  (operands)
  );

endmodule

`default_nettype wire

/* hw/operand_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

// operand fetch: tags out to the register file, values registered per unit
module operand_fetch import prf_pkg::*; #(
  parameter int NUM_FU = 2
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            en,                     // global freeze when low
  input  read_req_t       issue_req [NUM_FU],     // one request per unit
  output preg_idx_t       rd_tag_a  [NUM_FU],     // src1 to read port a
  output preg_idx_t       rd_tag_b  [NUM_FU],     // src2 to read port b
  input  reg_data_t       rd_val_a  [NUM_FU],     // forwarded src1 value
  input  reg_data_t       rd_val_b  [NUM_FU],     // forwarded src2 value
  output operand_packet_t operands  [NUM_FU]      // registered operands
);

  logic [NUM_FU-1:0] op_valid;           // packet valid per unit
  reg_data_t         op_a [NUM_FU];      // captured src1 value
  reg_data_t         op_b [NUM_FU];      // captured src2 value

  // tag routing, straight from the request
  always_comb begin
    for (int k = 0; k < NUM_FU; k++) begin
      rd_tag_a[k] = issue_req[k].src1;
      rd_tag_b[k] = issue_req[k].src2;
    end
  end

  // valid bits
  always_ff @(posedge clock) begin
    if (reset) begin
      op_valid <= '0;
    end else if (en) begin
      for (int k = 0; k < NUM_FU; k++) begin
        op_valid[k] <= issue_req[k].valid;     // one cycle per request
      end
    end
  end

  // operand values, read in the request cycle
  always_ff @(posedge clock) begin
    if (en) begin
      for (int k = 0; k < NUM_FU; k++) begin
        if (issue_req[k].valid) begin
          op_a[k] <= rd_val_a[k];              // bypass already applied
          op_b[k] <= rd_val_b[k];
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < NUM_FU; k++) begin
      operands[k].valid = op_valid[k];
      operands[k].opa   = op_a[k];
      operands[k].opb   = op_b[k];
    end
  end

endmodule

`default_nettype wire

/* hw/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// holding slot per unit, fixed priority grant, registered cdb broadcast
module cdb_arbiter import prf_pkg::*; #(
  parameter int NUM_FU = 2
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              en,                   // global freeze when low
  input  fu_result_t        fu_result [NUM_FU],   // finished results, strobed
  output logic [NUM_FU-1:0] fu_stall,             // unit must hold off
  output cdb_packet_t       cdb                   // one broadcast per cycle
);

  arb_state_t        slot_state [NUM_FU];  // per-unit slot state
  fu_result_t        slot_data  [NUM_FU];  // held result payload
  fu_result_t        cand       [NUM_FU];  // slot content after this edge
  logic [NUM_FU-1:0] take;                 // capture into the slot
  logic [NUM_FU-1:0] pending;              // holds a result at this edge
  logic [NUM_FU-1:0] grant;                // slot sent at this edge
  cdb_packet_t       cdb_next;             // broadcast for next cycle

  logic              bcast_valid;          // registered bus valid
  preg_idx_t         bcast_tag;            // registered bus tag
  reg_data_t         bcast_value;          // registered bus value

  always_comb begin
    for (int k = 0; k < NUM_FU; k++) begin
      pending[k] = (slot_state[k] == slot_full) || (en && fu_result[k].valid);
      cand[k]    = (slot_state[k] == slot_full) ? slot_data[k] : fu_result[k];  // bypass slot
    end
  end

  // lowest full slot wins, a result filled at this edge counts
  always_comb begin
    grant    = '0;
    cdb_next = '0;
    for (int k = 0; k < NUM_FU; k++) begin
      if (pending[k] && (grant == '0)) begin
        grant[k]       = 1'b1;
        cdb_next.valid = 1'b1;
        cdb_next.tag   = cand[k].tag;
        cdb_next.value = cand[k].value;
      end
    end
  end

  // stalled while frozen, or full and losing the grant
  always_comb begin
    for (int k = 0; k < NUM_FU; k++) begin
      fu_stall[k] = !en || ((slot_state[k] == slot_full) && !grant[k]);
      take[k]     = en && fu_result[k].valid && !fu_stall[k];  // empty or being sent
    end
  end

  // control state
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int k = 0; k < NUM_FU; k++) begin
        slot_state[k] <= slot_empty;
      end
      bcast_valid <= 1'b0;
    end else if (en) begin
      for (int k = 0; k < NUM_FU; k++) begin
        if (take[k] && ((slot_state[k] == slot_full) || !grant[k])) begin
          slot_state[k] <= slot_full;           // parked, or refilled as it is sent
        end else if (grant[k]) begin
          slot_state[k] <= slot_empty;          // sent, free again
        end
      end
      bcast_valid <= cdb_next.valid;            // one cycle per broadcast
    end
  end

  // payload, no reset
  always_ff @(posedge clock) begin
    if (en) begin
      for (int k = 0; k < NUM_FU; k++) begin
        if (take[k]) begin
          slot_data[k] <= fu_result[k];
        end
      end
      bcast_tag   <= cdb_next.tag;
      bcast_value <= cdb_next.value;
    end
  end

  assign cdb = '{valid: bcast_valid, tag: bcast_tag, value: bcast_value};

  // a result offered to a stalled slot is dropped
  for (genvar k = 0; k < NUM_FU; k++) begin : g_stall_chk
    a_no_result_while_stalled: assert property (
      @(posedge clock) disable iff (reset)
      fu_stall[k] |-> !fu_result[k].valid
    ) else $error("unit %0d presented a result while stalled", k);
  end

endmodule

`default_nettype wire

/* hw/phys_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

// physical register file, written from the cdb, forwarding on every read port
module phys_reg_file import prf_pkg::*; #(
  parameter int NUM_FU = 2
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        en,                     // global freeze when low
  input  cdb_packet_t cdb,                    // broadcast, doubles as write port
  input  preg_idx_t   rd_tag_a [NUM_FU],      // src1 tag per unit
  input  preg_idx_t   rd_tag_b [NUM_FU],      // src2 tag per unit
  output reg_data_t   rd_val_a [NUM_FU],      // src1 value per unit
  output reg_data_t   rd_val_b [NUM_FU]       // src2 value per unit
);

  reg_data_t regs [NUM_PREG];   // register storage
  logic      wr_hit;            // cdb carries a real write this cycle

  // only enabled, valid, non-zero-tag broadcasts touch the array
  assign wr_hit = en && cdb.valid && (cdb.tag != ZERO_PREG);

  // one read port: zero reg first, then bypass, then storage
  function automatic reg_data_t read_port(preg_idx_t tag);
    reg_data_t val;
    if (tag == ZERO_PREG) begin
      val = '0;                                 // hardwired zero
    end else if (wr_hit && (tag == cdb.tag)) begin
      val = cdb.value;                          // same-cycle forward
    end else begin
      val = regs[tag];
    end
    return val;
  endfunction

  always_comb begin
    for (int k = 0; k < NUM_FU; k++) begin
      rd_val_a[k] = read_port(rd_tag_a[k]);    // port a of unit k
      rd_val_b[k] = read_port(rd_tag_b[k]);    // port b of unit k
    end
  end

  // storage update, whole array clears on reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_PREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[cdb.tag] <= cdb.value;               // cdb write back
    end
  end

  // zero entry must survive every broadcast, tag 63 included
  a_zero_reg_holds_zero: assert property (
    @(posedge clock) disable iff (reset)
    regs[ZERO_PREG] == '0
  ) else $error("zero register holds a non-zero value");

endmodule

`default_nettype wire

/* hw/prf_pkg.sv */
`default_nettype none

// widths, tag/value types and the bus structs of the register file subsystem
package prf_pkg;

  localparam int PREG_IDX_W = 6;    // physical tag width
  localparam int NUM_PREG   = 64;   // one entry per tag value
  localparam int DATA_W     = 64;   // register value width

  typedef logic [PREG_IDX_W-1:0] preg_idx_t;  // physical register tag
  typedef logic [DATA_W-1:0]     reg_data_t;  // register value

  localparam preg_idx_t ZERO_PREG = preg_idx_t'(NUM_PREG - 1);  // reads zero, drops writes

  // finished result from one functional unit
  typedef struct packed {
    logic      valid;   // one-cycle strobe
    preg_idx_t tag;     // destination tag
    reg_data_t value;   // result value
  } fu_result_t;

  // common data bus broadcast
  typedef struct packed {
    logic      valid;   // broadcast this cycle
    preg_idx_t tag;     // written tag
    reg_data_t value;   // written value
  } cdb_packet_t;

  // issue request, two source tags
  typedef struct packed {
    logic      valid;
    preg_idx_t src1;    // goes to read port a
    preg_idx_t src2;    // goes to read port b
  } read_req_t;

  // fetched operands towards a unit
  typedef struct packed {
    logic      valid;
    reg_data_t opa;     // value of src1
    reg_data_t opb;     // value of src2
  } operand_packet_t;

  // per-unit holding slot in the cdb arbiter
  typedef enum logic {
    slot_empty = 1'b0,
    slot_full  = 1'b1
  } arb_state_t;

endpackage

`default_nettype wire
